// ==== design/snes_cart_pkg.sv ====
// ====================
// Shared widths, header offsets and encodings for the cartridge front end
// Import into each module body, use scoped names in port lists
// ====================
package snes_cart_pkg;

	// Host boot path
	localparam int BOOT_W     = 32;
	localparam int IOCTL_W    = 16;
	localparam int ADDR_W     = 24;
	localparam int BOOT_POS_W = 3;
	localparam logic [ADDR_W-1:0] ADDR_START = {{(ADDR_W-1){1'b1}}, 1'b0};

	// Copier header skip comes from the low file size bits
	localparam int SKIP_W = 10;

	// ====================
	// Internal header, low 15 address bits
	// ====================
	localparam int HDR_OFS_W = 15;
	localparam logic [HDR_OFS_W-1:0] HDR_MAPPER_OFS  = 15'h7FD4;
	localparam logic [HDR_OFS_W-1:0] HDR_TYPE_OFS    = 15'h7FD6;
	localparam logic [HDR_OFS_W-1:0] HDR_RAM_OFS     = 15'h7FD8;
	localparam logic [HDR_OFS_W-1:0] HDR_COMPANY_OFS = 15'h7FDA;

	typedef enum logic [1:0] {
		LOROM   = 2'd0,
		HIROM   = 2'd1,
		EXHIROM = 2'd2
	} rom_layout_e;

	// Upper nibble of the chip type
	typedef enum logic [3:0] {
		NONE = 4'h0,
		SDD1 = 4'h5,
		SA1  = 4'h6,
		GSU  = 4'h7,
		DSP1 = 4'h8,
		DSP2 = 4'h9,
		DSP3 = 4'hA,
		DSP4 = 4'hB,
		OBC1 = 4'hC
	} chip_kind_e;

	localparam logic [3:0] ROM_SIZE_MIN   = 4'd7;
	localparam logic [3:0] ROM_SIZE_DFLT  = 4'd12;
	localparam logic [3:0] GSU_RAM_CODE   = 4'd6;
	localparam logic [3:0] ST_SMALL_LIMIT = 4'd10;

	// ====================
	// Pads
	// ====================
	localparam int PAD_W = 12;

	typedef enum logic [1:0] {
		MAP_A = 2'd0,
		MAP_B = 2'd1,
		MAP_C = 2'd2,
		MAP_D = 2'd3
	} pad_map_e;

	// Six-button source word
	localparam int SEGA_UP    = 0;
	localparam int SEGA_DOWN  = 1;
	localparam int SEGA_LEFT  = 2;
	localparam int SEGA_RIGHT = 3;
	localparam int SEGA_B     = 4;
	localparam int SEGA_C     = 5;
	localparam int SEGA_A     = 6;
	localparam int SEGA_START = 7;
	localparam int SEGA_Z     = 8;
	localparam int SEGA_Y     = 9;
	localparam int SEGA_X     = 10;
	localparam int SEGA_MODE  = 11;

	// Console controller word
	localparam int PAD_RIGHT  = 0;
	localparam int PAD_LEFT   = 1;
	localparam int PAD_DOWN   = 2;
	localparam int PAD_UP     = 3;
	localparam int PAD_A      = 4;
	localparam int PAD_B      = 5;
	localparam int PAD_X      = 6;
	localparam int PAD_Y      = 7;
	localparam int PAD_L      = 8;
	localparam int PAD_R      = 9;
	localparam int PAD_SELECT = 10;
	localparam int PAD_START  = 11;

endpackage

// ==== design/boot_loader.sv ====
// ====================
// Host boot word unpacker
// Each 32-bit word held on the request level becomes eight ROM write
// strobes over two byte addresses, then one acknowledge pulse
// ====================
`timescale 1ns/1ps

module boot_loader (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              host_reset_loader_i,
	input  logic                              bootdata_req_i,
	input  logic [snes_cart_pkg::BOOT_W-1:0]  bootdata_i,
	output logic                              bootdata_ack_o,
	output logic                              ioctl_wr_o,
	output logic [snes_cart_pkg::ADDR_W-1:0]  ioctl_addr_o,
	output logic [snes_cart_pkg::IOCTL_W-1:0] ioctl_dout_o
);

	import snes_cart_pkg::*;

	logic [BOOT_POS_W-1:0] pos;
	logic                  accept;
	logic                  upper_half;

	// A word is taken while requested and not yet acknowledged
	assign accept = bootdata_req_i && !bootdata_ack_o;

	// Positions 0..3 carry the upper half, 4..7 the lower half
	assign upper_half = !pos[BOOT_POS_W-1];

	// ====================
	// Control
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset || host_reset_loader_i) begin
			bootdata_ack_o <= 1'b0;
			ioctl_wr_o     <= 1'b0;
			ioctl_addr_o   <= ADDR_START;
			pos            <= '0;
		end else if (accept) begin
			ioctl_wr_o <= 1'b1;
			pos        <= pos + 1'b1;
			// New address at the start of each half word
			if (pos == BOOT_POS_W'(0) || pos == BOOT_POS_W'(4)) begin
				ioctl_addr_o <= ioctl_addr_o + ADDR_W'(2);
			end
			// Last strobe of the word
			bootdata_ack_o <= (pos == {BOOT_POS_W{1'b1}});
		end else begin
			// Gap after the ack, or host held off
			bootdata_ack_o <= 1'b0;
			ioctl_wr_o     <= 1'b0;
		end
	end

	// Byte-swapped data
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			if (upper_half) begin
				ioctl_dout_o <= {bootdata_i[23:16], bootdata_i[31:24]};
			end else begin
				ioctl_dout_o <= {bootdata_i[7:0], bootdata_i[15:8]};
			end
		end
	end

endmodule

// ==== design/rom_header_parser.sv ====
// ====================
// ROM header parser
// Snoops ROM writes during a download, captures the internal header and
// builds the address masks; classifies the coprocessor once idle
// ====================
`timescale 1ns/1ps

module rom_header_parser (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               download_i,
	input  logic                               ioctl_wr_i,
	input  logic [snes_cart_pkg::ADDR_W-1:0]   ioctl_addr_i,
	input  logic [snes_cart_pkg::IOCTL_W-1:0]  ioctl_dout_i,
	input  logic [snes_cart_pkg::SKIP_W-1:0]   filesize_i,
	input  snes_cart_pkg::rom_layout_e         layout_i,
	output logic [7:0]                         rom_type_o,
	output logic [snes_cart_pkg::ADDR_W-1:0]   rom_mask_o,
	output logic [snes_cart_pkg::ADDR_W-1:0]   ram_mask_o
);

	import snes_cart_pkg::*;

	logic                        wr_q;
	logic                        wr_edge;
	logic [ADDR_W-1:0]           addr_adj;
	logic [ADDR_W-HDR_OFS_W-1:0] hdr_prefix;
	logic [7:0]                  mapper_hdr;
	logic [7:0]                  type_hdr;
	logic [7:0]                  company_hdr;
	logic [3:0]                  rom_size;
	logic [3:0]                  ram_size;
	logic [3:0]                  rom_code;
	chip_kind_e                  chip_kind;
	logic                        is_st0xx;
	logic [3:0]                  kind_nibble;

	// 1 KiB shifted by a size code, minus one
	function automatic logic [ADDR_W-1:0] size_mask(input logic [3:0] code);
		return (ADDR_W'(1024) << code) - ADDR_W'(1);
	endfunction

	// Both edges of the strobe mark a new half word
	assign wr_edge = ioctl_wr_i ^ wr_q;

	// Drop the 512-byte copier header if present
	assign addr_adj = ioctl_addr_i - ADDR_W'(filesize_i);

	// Bank bits above the 15-bit offset
	always_comb begin
		case (layout_i)
			HIROM:   hdr_prefix = (ADDR_W-HDR_OFS_W)'(9'h001);
			EXHIROM: hdr_prefix = (ADDR_W-HDR_OFS_W)'(9'h081);
			default: hdr_prefix = '0;
		endcase
	end

	assign rom_code = (rom_size < ROM_SIZE_MIN) ? ROM_SIZE_DFLT : rom_size;

	// ====================
	// Chip classification
	// ====================
	always_comb begin
		is_st0xx = 1'b0;
		if (mapper_hdr == 8'h30 && type_hdr == 8'h05 && company_hdr == 8'hB2)
			chip_kind = DSP3;
		else if (((mapper_hdr == 8'h20 || mapper_hdr == 8'h21) && type_hdr == 8'h03) ||
				(mapper_hdr == 8'h30 && type_hdr == 8'h05) ||
				(mapper_hdr == 8'h31 && (type_hdr == 8'h03 || type_hdr == 8'h05)))
			chip_kind = DSP1;
		else if (mapper_hdr == 8'h20 && type_hdr == 8'h05)
			chip_kind = DSP2;
		else if (mapper_hdr == 8'h30 && type_hdr == 8'h03)
			chip_kind = DSP4;
		else if (mapper_hdr == 8'h30 && type_hdr == 8'h25)
			chip_kind = OBC1;
		else if (mapper_hdr == 8'h32 && (type_hdr == 8'h43 || type_hdr == 8'h45))
			chip_kind = SDD1;
		else if (mapper_hdr == 8'h30 && type_hdr == 8'hF6) begin
			// ST010/ST011 share the DSP1 slot
			chip_kind = DSP1;
			is_st0xx  = 1'b1;
		end else if (mapper_hdr == 8'h20 && (type_hdr == 8'h13 || type_hdr == 8'h14 ||
				type_hdr == 8'h15 || type_hdr == 8'h1A))
			chip_kind = GSU;
		else if (mapper_hdr == 8'h23 &&
				(type_hdr == 8'h32 || type_hdr == 8'h34 || type_hdr == 8'h35))
			chip_kind = SA1;
		else
			chip_kind = NONE;

		kind_nibble = chip_kind;
		// Small ST0XX image sets type bit 5
		if (is_st0xx && rom_size < ST_SMALL_LIMIT) begin
			kind_nibble[1] = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= ioctl_wr_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_type_o  <= '0;
			rom_mask_o  <= '0;
			ram_mask_o  <= '0;
			mapper_hdr  <= '0;
			type_hdr    <= '0;
			company_hdr <= '0;
			rom_size    <= '0;
			ram_size    <= '0;
		end else if (download_i) begin
			if (wr_edge) begin
				if (ioctl_addr_i == '0) begin
					ram_size   <= '0;
					rom_type_o <= {6'd0, layout_i};
				end
				if (addr_adj == {hdr_prefix, HDR_MAPPER_OFS})
					mapper_hdr <= ioctl_dout_i[15:8];
				if (addr_adj == {hdr_prefix, HDR_TYPE_OFS})
					{rom_size, type_hdr} <= ioctl_dout_i[11:0];
				if (addr_adj == {hdr_prefix, HDR_RAM_OFS})
					ram_size <= ioctl_dout_i[3:0];
				if (addr_adj == {hdr_prefix, HDR_COMPANY_OFS})
					company_hdr <= ioctl_dout_i[7:0];

				// Settles one sample after the size field lands
				rom_mask_o <= size_mask(rom_code);
				ram_mask_o <= (ram_size != 4'd0) ? size_mask(ram_size) : '0;
			end
		end else begin
			if (chip_kind != NONE) begin
				rom_type_o[7:4] <= kind_nibble;
			end
			if (is_st0xx) begin
				rom_type_o[3] <= 1'b1;
			end
			// GSU carts get a fixed work RAM size
			if (chip_kind == GSU) begin
				ram_mask_o <= size_mask(GSU_RAM_CODE);
			end
		end
	end

endmodule

// ==== design/pad_mapper.sv ====
// ====================
// Six-button pad to console controller remap
// Per-player layout select, optional port swap, one register stage
// ====================
`timescale 1ns/1ps

module pad_mapper (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            swap_i,
	input  snes_cart_pkg::pad_map_e         map_p1_i,
	input  snes_cart_pkg::pad_map_e         map_p2_i,
	input  logic [snes_cart_pkg::PAD_W-1:0] pad1_n_i,
	input  logic [snes_cart_pkg::PAD_W-1:0] pad2_n_i,
	output logic [snes_cart_pkg::PAD_W-1:0] port1_o,
	output logic [snes_cart_pkg::PAD_W-1:0] port2_o
);

	import snes_cart_pkg::*;

	logic [PAD_W-1:0] map1;
	logic [PAD_W-1:0] map2;

	function automatic logic [PAD_W-1:0] map_pad(
		input logic [PAD_W-1:0] pad_n,
		input pad_map_e         map_sel
	);
		logic [PAD_W-1:0] p;
		logic [PAD_W-1:0] q;
		p = ~pad_n;
		q = '0;

		// D-pad, start and select are fixed
		q[PAD_UP]     = p[SEGA_UP];
		q[PAD_DOWN]   = p[SEGA_DOWN];
		q[PAD_LEFT]   = p[SEGA_LEFT];
		q[PAD_RIGHT]  = p[SEGA_RIGHT];
		q[PAD_START]  = p[SEGA_START];
		q[PAD_SELECT] = p[SEGA_MODE];

		// Face and shoulder buttons, order R L Y X B A
		case (map_sel)
			MAP_B: {q[PAD_R], q[PAD_L], q[PAD_Y], q[PAD_X], q[PAD_B], q[PAD_A]} =
				{p[SEGA_X], p[SEGA_A], p[SEGA_B], p[SEGA_C], p[SEGA_Y], p[SEGA_Z]};
			MAP_C: {q[PAD_R], q[PAD_L], q[PAD_Y], q[PAD_X], q[PAD_B], q[PAD_A]} =
				{p[SEGA_A], p[SEGA_X], p[SEGA_Y], p[SEGA_Z], p[SEGA_B], p[SEGA_C]};
			MAP_D: {q[PAD_R], q[PAD_L], q[PAD_Y], q[PAD_X], q[PAD_B], q[PAD_A]} =
				{p[SEGA_C], p[SEGA_B], p[SEGA_A], p[SEGA_Z], p[SEGA_X], p[SEGA_Y]};
			default: {q[PAD_R], q[PAD_L], q[PAD_Y], q[PAD_X], q[PAD_B], q[PAD_A]} =
				{p[SEGA_Z], p[SEGA_X], p[SEGA_Y], p[SEGA_A], p[SEGA_B], p[SEGA_C]};
		endcase
		return q;
	endfunction

	assign map1 = map_pad(pad1_n_i, map_p1_i);
	assign map2 = map_pad(pad2_n_i, map_p2_i);

	// ====================
	// Output ports
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port1_o <= '0;
			port2_o <= '0;
		end else if (swap_i) begin
			port1_o <= map2;
			port2_o <= map1;
		end else begin
			port1_o <= map1;
			port2_o <= map2;
		end
	end

endmodule

// ==== design/snes_cart_top.sv ====
// ====================
// Cartridge loading front end
// Boot loader feeds the header parser; pad remap and region latch
// sit alongside
// ====================
`timescale 1ns/1ps

module snes_cart_top (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              host_reset_loader_i,
	input  logic                              bootdata_req_i,
	input  logic [snes_cart_pkg::BOOT_W-1:0]  bootdata_i,
	input  logic                              download_i,
	input  logic [snes_cart_pkg::SKIP_W-1:0]  filesize_i,
	input  snes_cart_pkg::rom_layout_e        layout_i,
	input  logic                              region_i,
	input  logic                              swap_i,
	input  snes_cart_pkg::pad_map_e           map_p1_i,
	input  snes_cart_pkg::pad_map_e           map_p2_i,
	input  logic [snes_cart_pkg::PAD_W-1:0]   pad1_n_i,
	input  logic [snes_cart_pkg::PAD_W-1:0]   pad2_n_i,
	output logic                              bootdata_ack_o,
	output logic [7:0]                        rom_type_o,
	output logic [snes_cart_pkg::ADDR_W-1:0]  rom_mask_o,
	output logic [snes_cart_pkg::ADDR_W-1:0]  ram_mask_o,
	output logic                              pal_o,
	output logic [snes_cart_pkg::PAD_W-1:0]   port1_o,
	output logic [snes_cart_pkg::PAD_W-1:0]   port2_o
);

	import snes_cart_pkg::*;

	logic               ioctl_wr;
	logic [ADDR_W-1:0]  ioctl_addr;
	logic [IOCTL_W-1:0] ioctl_dout;

	boot_loader boot_loader_inst (
		.clk_sys             (clk_sys),
		.reset               (reset),
		.host_reset_loader_i (host_reset_loader_i),
		.bootdata_req_i      (bootdata_req_i),
		.bootdata_i          (bootdata_i),
		.bootdata_ack_o      (bootdata_ack_o),
		.ioctl_wr_o          (ioctl_wr),
		.ioctl_addr_o        (ioctl_addr),
		.ioctl_dout_o        (ioctl_dout)
	);

	rom_header_parser rom_header_parser_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download_i   (download_i),
		.ioctl_wr_i   (ioctl_wr),
		.ioctl_addr_i (ioctl_addr),
		.ioctl_dout_i (ioctl_dout),
		.filesize_i   (filesize_i),
		.layout_i     (layout_i),
		.rom_type_o   (rom_type_o),
		.rom_mask_o   (rom_mask_o),
		.ram_mask_o   (ram_mask_o)
	);

	pad_mapper pad_mapper_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.swap_i   (swap_i),
		.map_p1_i (map_p1_i),
		.map_p2_i (map_p2_i),
		.pad1_n_i (pad1_n_i),
		.pad2_n_i (pad2_n_i),
		.port1_o  (port1_o),
		.port2_o  (port2_o)
	);

	// Region only changes while no image is loading
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal_o <= 1'b0;
		end else if (!download_i) begin
			pal_o <= region_i;
		end
	end

endmodule

// ==== testbench/cart_checker.sv ====
// ====================
// Output checker for the cartridge front end
// Compares DUT outputs when the testbench raises a check strobe,
// and watches the boot acknowledge on every cycle
// ====================
`timescale 1ns/1ps

module cart_checker (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             chk_cart_i,
	input  logic                             chk_pads_i,
	input  logic                             chk_pal_i,
	input  logic [7:0]                       exp_type_i,
	input  logic [snes_cart_pkg::ADDR_W-1:0] exp_rom_mask_i,
	input  logic [snes_cart_pkg::ADDR_W-1:0] exp_ram_mask_i,
	input  int                               exp_acks_i,
	input  logic [snes_cart_pkg::PAD_W-1:0]  exp_port1_i,
	input  logic [snes_cart_pkg::PAD_W-1:0]  exp_port2_i,
	input  logic                             exp_pal_i,
	input  logic                             bootdata_req_i,
	input  logic                             bootdata_ack_i,
	input  logic [7:0]                       rom_type_i,
	input  logic [snes_cart_pkg::ADDR_W-1:0] rom_mask_i,
	input  logic [snes_cart_pkg::ADDR_W-1:0] ram_mask_i,
	input  logic                             pal_i,
	input  logic [snes_cart_pkg::PAD_W-1:0]  port1_i,
	input  logic [snes_cart_pkg::PAD_W-1:0]  port2_i,
	output int                               check_count_o,
	output int                               error_count_o
);

	logic ack_q;
	int   ack_count;
	int   req_cycles;

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count_o++;
		if (got !== exp) begin
			error_count_o++;
			$display("[FAIL] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// Strobes and DUT outputs are sampled before the edge updates them
	always @(posedge clk_sys) begin
		if (reset) begin
			ack_q         <= 1'b0;
			ack_count     <= 0;
			req_cycles    <= 0;
			check_count_o = 0;
			error_count_o = 0;
		end else begin
			ack_q <= bootdata_ack_i;
			if (bootdata_ack_i && !ack_q) begin
				ack_count <= ack_count + 1;
			end
			// Each word spans 8 strobes and the acknowledge gap
			if (bootdata_ack_i) begin
				compare("boot word length in cycles", req_cycles + 1, 9);
				req_cycles <= 0;
			end else if (bootdata_req_i) begin
				req_cycles <= req_cycles + 1;
			end
			// One-cycle pulse per word
			if (bootdata_ack_i && ack_q) begin
				error_count_o++;
				$display("[FAIL] %0t: bootdata_ack_o high for two cycles in a row", $time);
			end
			if (chk_cart_i) begin
				compare("rom_type_o", 32'(rom_type_i), 32'(exp_type_i));
				compare("rom_mask_o", 32'(rom_mask_i), 32'(exp_rom_mask_i));
				compare("ram_mask_o", 32'(ram_mask_i), 32'(exp_ram_mask_i));
				compare("acknowledge count", ack_count, exp_acks_i);
			end
			if (chk_pads_i) begin
				compare("port1_o", 32'(port1_i), 32'(exp_port1_i));
				compare("port2_o", 32'(port2_i), 32'(exp_port2_i));
			end
			if (chk_pal_i) begin
				compare("pal_o", 32'(pal_i), 32'(exp_pal_i));
			end
		end
	end

endmodule

// ==== testbench/tb_snes_cart.sv ====
// ====================
// Testbench for the cartridge front end
// Replays the golden file: region steps, boot images and pad vectors
// Compile with vlog.f, top module tb_snes_cart
// ====================
`timescale 1ns/1ps

module tb_snes_cart;

	import snes_cart_pkg::*;

	localparam int ACK_TIMEOUT = 32;
	localparam int MAX_HDR     = 8;

	logic               clk_sys;
	logic               reset;
	logic               host_reset_loader;
	logic               bootdata_req;
	logic [BOOT_W-1:0]  bootdata;
	logic               download;
	logic [SKIP_W-1:0]  filesize;
	rom_layout_e        layout;
	logic               region;
	logic               swap;
	pad_map_e           map_p1;
	pad_map_e           map_p2;
	logic [PAD_W-1:0]   pad1_n;
	logic [PAD_W-1:0]   pad2_n;
	logic               bootdata_ack;
	logic [7:0]         rom_type;
	logic [ADDR_W-1:0]  rom_mask;
	logic [ADDR_W-1:0]  ram_mask;
	logic               pal;
	logic [PAD_W-1:0]   port1;
	logic [PAD_W-1:0]   port2;

	// Checker control
	logic               chk_cart;
	logic               chk_pads;
	logic               chk_pal;
	logic [7:0]         exp_type;
	logic [ADDR_W-1:0]  exp_rom_mask;
	logic [ADDR_W-1:0]  exp_ram_mask;
	logic [PAD_W-1:0]   exp_port1;
	logic [PAD_W-1:0]   exp_port2;
	logic               exp_pal;
	int                 words_sent;
	int                 check_count;
	int                 error_count;

	// Golden file state
	integer             fd;
	integer             code;
	integer             seed;
	bit                 aborted;
	logic [31:0]        tag;
	logic [8*160-1:0]   line;
	logic [31:0]        f0;
	logic [31:0]        f1;
	logic [31:0]        f2;
	logic [31:0]        f3;
	logic [31:0]        f4;
	logic [31:0]        f5;
	logic [31:0]        f6;
	logic [31:0]        hdr_addr [MAX_HDR];
	logic [31:0]        hdr_word [MAX_HDR];
	int                 hdr_count;
	int                 nwords;

	snes_cart_top snes_cart_top_inst (
		.clk_sys             (clk_sys),
		.reset               (reset),
		.host_reset_loader_i (host_reset_loader),
		.bootdata_req_i      (bootdata_req),
		.bootdata_i          (bootdata),
		.download_i          (download),
		.filesize_i          (filesize),
		.layout_i            (layout),
		.region_i            (region),
		.swap_i              (swap),
		.map_p1_i            (map_p1),
		.map_p2_i            (map_p2),
		.pad1_n_i            (pad1_n),
		.pad2_n_i            (pad2_n),
		.bootdata_ack_o      (bootdata_ack),
		.rom_type_o          (rom_type),
		.rom_mask_o          (rom_mask),
		.ram_mask_o          (ram_mask),
		.pal_o               (pal),
		.port1_o             (port1),
		.port2_o             (port2)
	);

	cart_checker cart_checker_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.chk_cart_i     (chk_cart),
		.chk_pads_i     (chk_pads),
		.chk_pal_i      (chk_pal),
		.exp_type_i     (exp_type),
		.exp_rom_mask_i (exp_rom_mask),
		.exp_ram_mask_i (exp_ram_mask),
		.exp_acks_i     (words_sent),
		.exp_port1_i    (exp_port1),
		.exp_port2_i    (exp_port2),
		.exp_pal_i      (exp_pal),
		.bootdata_req_i (bootdata_req),
		.bootdata_ack_i (bootdata_ack),
		.rom_type_i     (rom_type),
		.rom_mask_i     (rom_mask),
		.ram_mask_i     (ram_mask),
		.pal_i          (pal),
		.port1_i        (port1),
		.port2_i        (port2),
		.check_count_o  (check_count),
		.error_count_o  (error_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ====================
	// Helpers
	// ====================
	task automatic finish_run();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (!aborted && error_count == 0 && check_count > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	// Order is cart, pads, region
	task automatic pulse_check(input logic [2:0] which);
		{chk_cart, chk_pads, chk_pal} <= which;
		@(posedge clk_sys);
		{chk_cart, chk_pads, chk_pal} <= 3'b000;
	endtask

	// Hold the word until the loader acknowledges it
	task automatic send_word(input logic [BOOT_W-1:0] word);
		int waited;
		waited = 0;
		bootdata     <= word;
		bootdata_req <= 1'b1;
		do begin
			@(posedge clk_sys);
			waited++;
		end while (!bootdata_ack && waited < ACK_TIMEOUT);
		if (bootdata_ack) begin
			words_sent++;
		end else begin
			$display("Timeout: no acknowledge for boot word %0d", words_sent);
			aborted = 1'b1;
		end
	endtask

	// Random filler except where a header word is listed
	task automatic load_image();
		logic [BOOT_W-1:0] word;
		int k;
		int h;
		host_reset_loader <= 1'b1;
		@(posedge clk_sys);
		host_reset_loader <= 1'b0;
		download          <= 1'b1;
		@(posedge clk_sys);
		for (k = 0; k < nwords && !aborted; k++) begin
			word = $random(seed);
			for (h = 0; h < hdr_count; h++) begin
				if (hdr_addr[h] == k * 4) begin
					word = hdr_word[h];
				end
			end
			send_word(word);
		end
		bootdata_req <= 1'b0;
		@(posedge clk_sys);
		download <= 1'b0;
		// Chip type and masks are valid two cycles later
		repeat (2) @(posedge clk_sys);
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin
		reset             = 1'b1;
		host_reset_loader = 1'b0;
		bootdata_req      = 1'b0;
		bootdata          = '0;
		download          = 1'b0;
		filesize          = '0;
		layout            = LOROM;
		region            = 1'b0;
		swap              = 1'b0;
		map_p1            = MAP_A;
		map_p2            = MAP_A;
		pad1_n            = '1;
		pad2_n            = '1;
		{chk_cart, chk_pads, chk_pal} = 3'b000;
		exp_type          = '0;
		exp_rom_mask      = '0;
		exp_ram_mask      = '0;
		exp_port1         = '0;
		exp_port2         = '0;
		exp_pal           = 1'b0;
		words_sent        = 0;
		hdr_count         = 0;
		nwords            = 0;
		aborted           = 1'b0;
		seed              = 88541;

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);

		fd = $fopen("testbench/snes_cart_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open testbench/snes_cart_golden.txt");
			aborted = 1'b1;
		end else begin
			code = $fscanf(fd, "%s", tag);
			while (code == 1 && !aborted) begin
				case (tag)
					"#": code = $fgets(line, fd);
					"C": begin
						code = $fscanf(fd, "%h %h %h", f0, f1, f2);
						layout    <= rom_layout_e'(f0[1:0]);
						filesize  <= f1[SKIP_W-1:0];
						nwords    = f2;
						hdr_count = 0;
					end
					"W": begin
						code = $fscanf(fd, "%h %h", f0, f1);
						if (hdr_count < MAX_HDR) begin
							hdr_addr[hdr_count] = f0;
							hdr_word[hdr_count] = f1;
							hdr_count++;
						end
					end
					"E": begin
						code = $fscanf(fd, "%h %h %h", f0, f1, f2);
						load_image();
						exp_type     <= f0[7:0];
						exp_rom_mask <= f1[ADDR_W-1:0];
						exp_ram_mask <= f2[ADDR_W-1:0];
						pulse_check(3'b100);
					end
					"P": begin
						code = $fscanf(fd, "%h %h %h %h %h %h %h",
							f0, f1, f2, f3, f4, f5, f6);
						swap   <= f0[0];
						map_p1 <= pad_map_e'(f1[1:0]);
						map_p2 <= pad_map_e'(f2[1:0]);
						pad1_n <= f3[PAD_W-1:0];
						pad2_n <= f4[PAD_W-1:0];
						@(posedge clk_sys);
						exp_port1 <= f5[PAD_W-1:0];
						exp_port2 <= f6[PAD_W-1:0];
						pulse_check(3'b010);
					end
					"R": begin
						code = $fscanf(fd, "%h %h %h", f0, f1, f2);
						region   <= f0[0];
						download <= f1[0];
						@(posedge clk_sys);
						exp_pal <= f2[0];
						pulse_check(3'b001);
					end
					default: begin
						$display("Unknown record %s in golden file", tag);
						aborted = 1'b1;
					end
				endcase
				code = $fscanf(fd, "%s", tag);
			end
			$fclose(fd);
		end
		repeat (2) @(posedge clk_sys);
		finish_run();
	end

endmodule

// ==== vlog.f ====
design/snes_cart_pkg.sv
design/boot_loader.sv
design/rom_header_parser.sv
design/pad_mapper.sv
design/snes_cart_top.sv
testbench/cart_checker.sv
testbench/tb_snes_cart.sv

// ==== testbench/snes_cart_golden.txt ====
# R region download pal | C layout filesize nwords | W byte_addr word | E type rom_mask ram_mask
# P swap map_p1 map_p2 pad1_n pad2_n port1 port2 (all fields hex)
R 1 0 1
R 0 1 1
R 0 0 0
# LoROM, no copier header, DSP1
C 0 000 2000
W 7fd4 20200309
W 7fd8 01010000
E 80 07ffff 0007ff
# HiROM behind a 512-byte copier header, GSU
C 1 200 4080
W 101d4 20201a0a
W 101d8 05013300
E 71 0fffff 00ffff
# ExHiROM, ST0XX with a small ROM code
C 2 000 104000
W 40ffd4 2030f609
W 40ffd8 02000000
E aa 07ffff 000fff
# LoROM, plain header, ROM code below the minimum
C 0 000 2000
W 7fd4 20200205
W 7fd8 03010100
E 00 3fffff 001fff
P 0 0 1 fbe e7f 048 810
P 1 2 3 3f7 fdd 204 501
P 0 3 2 def deb 110 0a2
P 1 1 0 fff 000 fff 000
P 0 1 0 bdf bdf 240 110
R 1 1 0
R 1 0 1
